// File: flist.f
hdl/cpuPkg.sv
hdl/cpuIfs.sv
hdl/aluUnit.sv
hdl/regFile.sv
hdl/controlFsm.sv
hdl/datapath.sv
hdl/mainMemory.sv
hdl/cpuTop.sv
tb/tbCpu.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbCpu -f flist.f -o simv

out=$(./obj_dir/simv)
echo "$out"

echo "$out" | grep -qx "TEST OK"

// File: tb/tbCpu.sv
`timescale 1ns/1ps

module tbCpu;

        localparam int stepCap = 300;           // model instruction limit
        localparam int waitCap = 1 + 5 * stepCap + 20;

        logic clock;
        logic reset;
        logic hostEn;
        logic hostWe;
        logic [7:0] hostAddr;
        logic [7:0] hostWdata;
        logic [7:0] hostRdata;
        logic stopped;
        logic [7:0] pcOut;

        logic [7:0] initImage [256];
        logic [7:0] refMem [256];
        logic [7:0] refRegs [4];
        logic [7:0] refPc;
        logic refN;
        logic refZ;
        logic [31:0] seed;
        int progLen;
        int errors;
        logic timedOut;

        cpuTop dut0 (
                .clock       (clock),
                .reset       (reset),
                .i_hostEn    (hostEn),
                .i_hostWe    (hostWe),
                .i_hostAddr  (hostAddr),
                .i_hostWdata (hostWdata),
                .o_hostRdata (hostRdata),
                .o_stopped   (stopped),
                .o_pc        (pcOut)
        );

        always #2 clock = ~clock;

        function automatic logic [31:0] lcgNext(input logic [31:0] s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        function automatic logic [7:0] encReg(input int ra, input int rb, input logic [3:0] op);
                return {2'(ra), 2'(rb), op};
        endfunction

        function automatic void setResult(input int ra, input logic [7:0] res);
                refRegs[ra] = res;
                refN = res[7];
                refZ = (res == 8'd0);
        endfunction

        // instruction-set model on refMem, returns executed non-stop count or -1
        function automatic int runModel();
                logic [7:0] ins;
                logic [7:0] x;
                logic [3:0] op;
                logic [2:0] mag;
                int ra;
                int rb;
                refPc = 8'd0;
                refN = 1'b0;
                refZ = 1'b0;
                for (int i = 0; i < 4; i++)
                        refRegs[i] = 8'd0;
                for (int step = 0; step < stepCap; step++) begin
                        ins = refMem[refPc];
                        refPc = refPc + 8'd1;
                        op = ins[3:0];
                        ra = int'(ins[7:6]);
                        rb = int'(ins[5:4]);
                        x = refRegs[ra];
                        mag = 3'd0 - ins[5:3];
                        if (op == cpuPkg::opAdd)
                                setResult(ra, x + refRegs[rb]);
                        else if (op == cpuPkg::opSub)
                                setResult(ra, x - refRegs[rb]);
                        else if (op == cpuPkg::opNand)
                                setResult(ra, ~(x & refRegs[rb]));
                        else if (op[2:0] == 3'd3)
                                setResult(ra, ins[5] ? (x >> mag) : (x << ins[5:3]));
                        else if (op[2:0] == 3'd7)
                                setResult(1, refRegs[1] | {3'b000, ins[7:3]});
                        else if (op == cpuPkg::opLoad)
                                refRegs[ra] = refMem[refRegs[rb]];
                        else if (op == cpuPkg::opStore)
                                refMem[refRegs[rb]] = x;
                        else if (op == cpuPkg::opStop)
                                return step;
                        else if ((op == cpuPkg::opBz && refZ) || (op == cpuPkg::opBnz && !refZ) ||
                                 (op == cpuPkg::opBpz && !refN))
                                refPc = refPc + {{4{ins[7]}}, ins[7:4]};
                end
                return -1;
        endfunction

        task automatic fillImage();
                for (int a = 0; a < 256; a++)
                        initImage[a] = 8'(a * 59) ^ 8'hA5;
                progLen = 0;
        endtask

        task automatic emit(input logic [7:0] b);
                initImage[progLen] = b;
                progLen++;
        endtask

        task automatic error(input string msg);
                errors++;
                $display("[ERROR] t=%0t %s", $time, msg);
        endtask

        task automatic runProgram(input string name);
                int n;
                int cycles;
                for (int a = 0; a < 256; a++)
                        refMem[a] = initImage[a];
                n = runModel();
                @(posedge clock);
                #1 reset = 1'b1;
                hostEn = 1'b1;
                for (int a = 0; a < 256; a++) begin
                        hostWe = 1'b1;
                        hostAddr = 8'(a);
                        hostWdata = initImage[a];
                        @(posedge clock);
                        #1;
                end
                hostWe = 1'b0;
                hostEn = 1'b0;
                repeat (4) @(posedge clock);
                #1 reset = 1'b0;
                if (stopped !== 1'b0)
                        error($sformatf("%s: stopped high right after reset", name));
                cycles = 0;
                while (stopped !== 1'b1 && cycles < waitCap) begin
                        @(posedge clock);
                        #1 cycles++;
                end
                if (stopped !== 1'b1) begin
                        $display("%s: the CPU did not stop within %0d cycles", name, waitCap);
                        timedOut = 1'b1;
                        return;
                end
                if (cycles != 1 + 5 * n + 3)
                        error($sformatf("%s: halt after %0d cycles, expected %0d",
                                        name, cycles, 1 + 5 * n + 3));
                repeat (3) begin
                        @(posedge clock);
                        #1;
                        if (stopped !== 1'b1)
                                error($sformatf("%s: stopped fell while halted", name));
                end
                if (pcOut !== refPc)
                        error($sformatf("%s: pc %h, expected %h", name, pcOut, refPc));
                hostEn = 1'b1;
                for (int a = 0; a < 256; a++) begin
                        @(posedge clock);
                        #1 hostAddr = 8'(a);
                        @(negedge clock);
                        if (hostRdata !== refMem[a])
                                error($sformatf("%s: mem[%h] = %h, expected %h",
                                                name, a, hostRdata, refMem[a]));
                end
        endtask

        task automatic buildAluProg();
                fillImage();
                emit({5'h15, 3'b111});                  // ori r1 = 0x15
                emit(encReg(2, 1, cpuPkg::opAdd));
                emit({5'h1A, 3'b111});
                emit(encReg(3, 1, cpuPkg::opAdd));
                emit(encReg(2, 3, cpuPkg::opSub));
                emit(8'h0C);                            // unknown opcodes
                emit(encReg(3, 2, cpuPkg::opNand));
                emit(8'hEE);
                emit(encReg(1, 1, cpuPkg::opAdd));      // r1 = 0x3e, data address
                emit(encReg(2, 1, cpuPkg::opStore));
                emit(encReg(0, 2, cpuPkg::opAdd));
                emit(encReg(1, 1, cpuPkg::opAdd));
                emit(encReg(3, 1, cpuPkg::opStore));
                emit({4'h0, cpuPkg::opNop});
                emit({2'd1, 3'd1, 3'b011});             // shift r1 left by one
                emit(encReg(0, 1, cpuPkg::opStore));
                emit(encReg(0, 0, cpuPkg::opStop));
        endtask

        task automatic buildShiftProg();
                fillImage();
                emit({5'h11, 3'b111});
                emit(encReg(2, 1, cpuPkg::opAdd));
                emit(encReg(2, 2, cpuPkg::opNand));     // r2 = 0xee, the shifted value
                repeat (4) emit(encReg(0, 1, cpuPkg::opAdd));
                for (int k = 0; k < 8; k++) begin
                        emit(encReg(3, 3, cpuPkg::opSub));
                        emit(encReg(3, 2, cpuPkg::opAdd));
                        emit({2'd3, 3'(k), 3'b011});
                        emit(encReg(3, 0, cpuPkg::opStore));
                        emit(encReg(0, 1, cpuPkg::opAdd));
                end
                emit(encReg(3, 0, cpuPkg::opLoad));     // load-modify-store of fill data
                emit(encReg(3, 2, cpuPkg::opAdd));
                emit(encReg(3, 0, cpuPkg::opStore));
                emit(encReg(0, 0, cpuPkg::opStop));
        endtask

        task automatic buildBranchProg();
                fillImage();
                emit({5'h01, 3'b111});
                emit(encReg(3, 1, cpuPkg::opAdd));      // r3 = 1
                emit({5'h04, 3'b111});
                emit(encReg(2, 1, cpuPkg::opAdd));      // counter = 5
                emit(encReg(0, 1, cpuPkg::opAdd));
                emit({2'd0, 3'd3, 3'b011});
                emit({2'd0, 3'd3, 3'b011});             // r0 = 0x40
                emit(encReg(2, 0, cpuPkg::opStore));
                emit(encReg(0, 3, cpuPkg::opAdd));
                emit(encReg(2, 3, cpuPkg::opSub));
                emit({4'hC, cpuPkg::opBnz});            // back four
                emit({4'h1, cpuPkg::opBz});             // taken
                emit(encReg(3, 0, cpuPkg::opStore));
                emit({4'h1, cpuPkg::opBpz});            // taken
                emit(encReg(3, 0, cpuPkg::opStore));
                emit(encReg(2, 3, cpuPkg::opSub));      // negative
                emit({4'h1, cpuPkg::opBpz});
                emit(encReg(2, 0, cpuPkg::opStore));
                emit({4'h1, cpuPkg::opBz});
                emit(encReg(3, 0, cpuPkg::opStore));
                emit(encReg(0, 0, cpuPkg::opStop));
        endtask

        task automatic buildRandomProg();
                logic [7:0] b;
                int len;
                int maxOff;
                do begin
                        fillImage();
                        seed = lcgNext(seed);
                        len = 12 + int'(seed[23:16] % 9);
                        for (int i = 0; i < len - 1; i++) begin
                                seed = lcgNext(seed);
                                b = seed[23:16];
                                if (b[3:0] == cpuPkg::opStop)
                                        b[3:0] = cpuPkg::opNop;
                                if (b[3:0] == cpuPkg::opBz || b[3:0] == cpuPkg::opBnz ||
                                    b[3:0] == cpuPkg::opBpz) begin
                                        maxOff = (len - 2 - i > 7) ? 7 : len - 2 - i;
                                        b[7:4] = 4'(int'(seed[31:24]) % (maxOff + 1));
                                end
                                emit(b);
                        end
                        seed = lcgNext(seed);
                        emit({seed[23:20], cpuPkg::opStop});
                        for (int a = 0; a < 256; a++)
                                refMem[a] = initImage[a];
                end while (runModel() < 0);     // skip programs that rewrite themselves into loops
        endtask

        initial begin
                clock = 1'b0;
                reset = 1'b1;
                hostEn = 1'b0;
                hostWe = 1'b0;
                hostAddr = 8'd0;
                hostWdata = 8'd0;
                errors = 0;
                timedOut = 1'b0;
                seed = 32'h6568_1086;
                repeat (4) @(posedge clock);
                buildAluProg();
                runProgram("alu");
                buildShiftProg();
                if (!timedOut)
                        runProgram("shift");
                buildBranchProg();
                if (!timedOut)
                        runProgram("branch");
                for (int k = 0; k < 20 && !timedOut; k++) begin
                        buildRandomProg();
                        runProgram($sformatf("random%0d", k));
                end
                $display("checks done, errors: %0d, timeout: %0d", errors, timedOut);
                if (errors == 0 && !timedOut)
                        $display("TEST OK");
                else
                        $display("TEST FAILED");
                $finish;
        end

endmodule

// File: hdl/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
        input  logic         clock,
        input  logic         reset,
        input  logic         i_hostEn,
        input  logic         i_hostWe,
        input  cpuPkg::addrT i_hostAddr,
        input  cpuPkg::dataT i_hostWdata,
        output cpuPkg::dataT o_hostRdata,
        output logic         o_stopped,
        output cpuPkg::addrT o_pc
);

        ctrlIf ctrl0 ();
        memIf  mem0 ();

        controlFsm fsm0 (
                .clock     (clock),
                .reset     (reset),
                .ctrl      (ctrl0.seq),
                .o_stopped (o_stopped)
        );

        datapath dp0 (
                .clock (clock),
                .reset (reset),
                .ctrl  (ctrl0.dp),
                .mem   (mem0.core),
                .o_pc  (o_pc)
        );

        mainMemory ram0 (
                .clock       (clock),
                .mem         (mem0.mem),
                .i_hostEn    (i_hostEn),
                .i_hostWe    (i_hostWe),
                .i_hostAddr  (i_hostAddr),
                .i_hostWdata (i_hostWdata),
                .o_hostRdata (o_hostRdata)
        );

endmodule

// File: hdl/mainMemory.sv
`timescale 1ns/1ps

module mainMemory (
        input  logic         clock,
        memIf.mem            mem,
        input  logic         i_hostEn,
        input  logic         i_hostWe,
        input  cpuPkg::addrT i_hostAddr,
        input  cpuPkg::dataT i_hostWdata,
        output cpuPkg::dataT o_hostRdata
);

        cpuPkg::dataT ram [cpuPkg::memDepth];
        cpuPkg::addrT selAddr;
        cpuPkg::dataT selWdata;
        cpuPkg::dataT rdData;
        logic selWe;

        // host has priority whenever enabled
        assign selAddr = i_hostEn ? i_hostAddr : mem.addr;
        assign selWdata = i_hostEn ? i_hostWdata : mem.wdata;
        assign selWe = i_hostEn ? i_hostWe : mem.write;

        always_ff @(posedge clock) begin
                if (selWe)
                        ram[selAddr] <= selWdata;
        end

        assign rdData = ram[selAddr];
        assign o_hostRdata = rdData;
        assign mem.rdata = mem.read ? rdData : '0;

        aNoCoreWriteInHost: assert property (@(posedge clock) !(i_hostEn && mem.write));

endmodule

// File: hdl/datapath.sv
`timescale 1ns/1ps

module datapath (
        input  logic         clock,
        input  logic         reset,
        ctrlIf.dp            ctrl,
        memIf.core           mem,
        output cpuPkg::addrT o_pc
);

        cpuPkg::addrT   pc;
        cpuPkg::instrT  ir;
        cpuPkg::dataT   mdr;
        cpuPkg::dataT   r1Latch;
        cpuPkg::dataT   r2Latch;        // also the data address
        cpuPkg::dataT   aluOut;
        cpuPkg::dataT   rdA;
        cpuPkg::dataT   rdB;
        cpuPkg::dataT   aluA;
        cpuPkg::dataT   aluB;
        cpuPkg::dataT   aluResult;
        cpuPkg::dataT   wrData;
        cpuPkg::regIdxT r1Idx;
        logic aluN;
        logic aluZ;
        logic flagN;
        logic flagZ;

        // ori reads and writes register one
        assign r1Idx = ctrl.r1Sel ? cpuPkg::regIdxT'(1) : ir[cpuPkg::r1Hi:cpuPkg::r1Lo];
        assign wrData = ctrl.regIn ? mdr : aluOut;

        regFile regs0 (
                .clock    (clock),
                .reset    (reset),
                .i_rdIdxA (r1Idx),
                .i_rdIdxB (ir[cpuPkg::r2Hi:cpuPkg::r2Lo]),
                .o_rdA    (rdA),
                .o_rdB    (rdB),
                .i_we     (ctrl.rfWrite),
                .i_wrIdx  (r1Idx),
                .i_wrData (wrData)
        );

        assign aluA = ctrl.alu1Sel ? r1Latch : pc;

        always_comb begin
                case (ctrl.alu2Sel)
                cpuPkg::alu2One:  aluB = 8'd1;
                cpuPkg::alu2Imm4: aluB = {{4{ir[7]}}, ir[7:4]};
                cpuPkg::alu2Imm5: aluB = {3'b000, ir[7:3]};
                cpuPkg::alu2Imm3: aluB = {{5{ir[5]}}, ir[5:3]};     // signed shift amount
                default:          aluB = r2Latch;
                endcase
        end

        aluUnit alu0 (
                .i_a      (aluA),
                .i_b      (aluB),
                .i_op     (ctrl.aluOp),
                .o_result (aluResult),
                .o_n      (aluN),
                .o_z      (aluZ)
        );

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        pc <= '0;
                        flagN <= 1'b0;
                        flagZ <= 1'b0;
                end else begin
                        if (ctrl.pcWrite)
                                pc <= ctrl.pcSel ? aluOut : aluResult;  // branch target or pc + 1
                        if (ctrl.flagWrite) begin
                                flagN <= aluN;
                                flagZ <= aluZ;
                        end
                end
        end

        always_ff @(posedge clock) begin
                if (ctrl.irLoad)
                        ir <= mem.rdata;
                if (ctrl.mdrLoad)
                        mdr <= mem.rdata;
                if (ctrl.r1r2Load) begin
                        r1Latch <= rdA;
                        r2Latch <= rdB;
                end
                if (ctrl.aluOutWrite)
                        aluOut <= aluResult;
        end

        // fetched word straight from the bus during fetch
        assign ctrl.instr = ctrl.irLoad ? mem.rdata : ir;
        assign ctrl.flagN = flagN;
        assign ctrl.flagZ = flagZ;

        assign mem.addr = ctrl.irLoad ? pc : r2Latch;
        assign mem.wdata = r1Latch;
        assign mem.read = ctrl.memRead;
        assign mem.write = ctrl.memWrite;

        assign o_pc = pc;

endmodule

// File: hdl/controlFsm.sv
`timescale 1ns/1ps

module controlFsm (
        input  logic clock,
        input  logic reset,
        ctrlIf.seq   ctrl,
        output logic o_stopped
);

        cpuPkg::fsmStateT state;
        cpuPkg::fsmStateT nextState;
        logic [3:0] opcode;

        assign opcode = ctrl.instr[3:0];
        assign o_stopped = (state == cpuPkg::stHalted);

        always_comb begin
                nextState = cpuPkg::stReset;
                case (state)
                cpuPkg::stReset:   nextState = cpuPkg::stFetch;
                cpuPkg::stFetch:   nextState = cpuPkg::stDecode;
                cpuPkg::stDecode: begin
                        if (opcode == cpuPkg::opAdd || opcode == cpuPkg::opSub ||
                            opcode == cpuPkg::opNand)
                                nextState = cpuPkg::stC3Asn;
                        else if (opcode[2:0] == cpuPkg::opShift)
                                nextState = cpuPkg::stC3Shift;
                        else if (opcode[2:0] == cpuPkg::opOri)
                                nextState = cpuPkg::stC3Ori;
                        else begin
                                case (opcode)
                                cpuPkg::opLoad:  nextState = cpuPkg::stC3Load;
                                cpuPkg::opStore: nextState = cpuPkg::stC3Store;
                                cpuPkg::opBz:    nextState = cpuPkg::stC3Bz;
                                cpuPkg::opBnz:   nextState = cpuPkg::stC3Bnz;
                                cpuPkg::opBpz:   nextState = cpuPkg::stC3Bpz;
                                cpuPkg::opStop:  nextState = cpuPkg::stC3Stop;
                                default:         nextState = cpuPkg::stC3Nop; // nop and unknown
                                endcase
                        end
                end
                cpuPkg::stC3Asn, cpuPkg::stC3Shift: nextState = cpuPkg::stC4Asnsh;
                cpuPkg::stC3Ori:   nextState = cpuPkg::stC4Ori;
                cpuPkg::stC4Ori:   nextState = cpuPkg::stC5Ori;
                cpuPkg::stC3Load:  nextState = cpuPkg::stC4Load;
                cpuPkg::stC3Store, cpuPkg::stC3Bz, cpuPkg::stC3Bnz,
                cpuPkg::stC3Bpz, cpuPkg::stC3Nop: nextState = cpuPkg::stC4Idle;
                cpuPkg::stC3Stop:  nextState = cpuPkg::stHalted;
                cpuPkg::stC4Asnsh, cpuPkg::stC4Load,
                cpuPkg::stC4Idle:  nextState = cpuPkg::stC5Idle;
                cpuPkg::stC5Ori, cpuPkg::stC5Idle: nextState = cpuPkg::stFetch;
                cpuPkg::stHalted:  nextState = cpuPkg::stHalted;   // until reset
                default:           nextState = cpuPkg::stReset;
                endcase
        end

        always_ff @(posedge clock or posedge reset) begin
                if (reset)
                        state <= cpuPkg::stReset;
                else
                        state <= nextState;
        end

        always_comb begin
                ctrl.pcWrite = 1'b0;
                ctrl.pcSel = 1'b0;
                ctrl.memRead = 1'b0;
                ctrl.memWrite = 1'b0;
                ctrl.irLoad = 1'b0;
                ctrl.r1Sel = 1'b0;
                ctrl.mdrLoad = 1'b0;
                ctrl.r1r2Load = 1'b0;
                ctrl.alu1Sel = 1'b0;
                ctrl.alu2Sel = cpuPkg::alu2R2;
                ctrl.aluOp = cpuPkg::aluAdd;
                ctrl.aluOutWrite = 1'b0;
                ctrl.rfWrite = 1'b0;
                ctrl.regIn = 1'b0;
                ctrl.flagWrite = 1'b0;
                case (state)
                cpuPkg::stFetch: begin
                        ctrl.memRead = 1'b1;
                        ctrl.irLoad = 1'b1;
                        ctrl.pcWrite = 1'b1;            // pc + 1 through the alu
                        ctrl.alu2Sel = cpuPkg::alu2One;
                end
                cpuPkg::stDecode: begin
                        ctrl.r1r2Load = 1'b1;
                        ctrl.alu2Sel = cpuPkg::alu2Imm4; // branch target ahead of time
                        ctrl.aluOutWrite = 1'b1;
                end
                cpuPkg::stC3Asn: begin
                        ctrl.alu1Sel = 1'b1;
                        if (opcode == cpuPkg::opSub)
                                ctrl.aluOp = cpuPkg::aluSub;
                        else if (opcode == cpuPkg::opNand)
                                ctrl.aluOp = cpuPkg::aluNand;
                        ctrl.aluOutWrite = 1'b1;
                        ctrl.flagWrite = 1'b1;
                end
                cpuPkg::stC3Shift: begin
                        ctrl.alu1Sel = 1'b1;
                        ctrl.alu2Sel = cpuPkg::alu2Imm3;
                        ctrl.aluOp = cpuPkg::aluShift;
                        ctrl.aluOutWrite = 1'b1;
                        ctrl.flagWrite = 1'b1;
                end
                cpuPkg::stC4Asnsh: ctrl.rfWrite = 1'b1;
                cpuPkg::stC3Ori: begin
                        ctrl.r1Sel = 1'b1;
                        ctrl.r1r2Load = 1'b1;
                end
                cpuPkg::stC4Ori: begin
                        ctrl.alu1Sel = 1'b1;
                        ctrl.alu2Sel = cpuPkg::alu2Imm5;
                        ctrl.aluOp = cpuPkg::aluOr;
                        ctrl.aluOutWrite = 1'b1;
                        ctrl.flagWrite = 1'b1;
                end
                cpuPkg::stC5Ori: begin
                        ctrl.r1Sel = 1'b1;
                        ctrl.rfWrite = 1'b1;
                end
                cpuPkg::stC3Load: begin
                        ctrl.memRead = 1'b1;
                        ctrl.mdrLoad = 1'b1;
                end
                cpuPkg::stC4Load: begin
                        ctrl.rfWrite = 1'b1;
                        ctrl.regIn = 1'b1;
                end
                cpuPkg::stC3Store: ctrl.memWrite = 1'b1;
                cpuPkg::stC3Bz: begin
                        ctrl.pcSel = 1'b1;
                        ctrl.pcWrite = ctrl.flagZ;
                end
                cpuPkg::stC3Bnz: begin
                        ctrl.pcSel = 1'b1;
                        ctrl.pcWrite = ~ctrl.flagZ;
                end
                cpuPkg::stC3Bpz: begin
                        ctrl.pcSel = 1'b1;
                        ctrl.pcWrite = ~ctrl.flagN;
                end
                default: ;
                endcase
        end

        aMemExclusive: assert property (@(posedge clock) disable iff (reset)
                !(ctrl.memRead && ctrl.memWrite));

endmodule

// File: hdl/regFile.sv
`timescale 1ns/1ps

module regFile (
        input  logic           clock,
        input  logic           reset,
        input  cpuPkg::regIdxT i_rdIdxA,
        input  cpuPkg::regIdxT i_rdIdxB,
        output cpuPkg::dataT   o_rdA,
        output cpuPkg::dataT   o_rdB,
        input  logic           i_we,
        input  cpuPkg::regIdxT i_wrIdx,
        input  cpuPkg::dataT   i_wrData
);

        cpuPkg::dataT regs [4];

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        for (int i = 0; i < 4; i++)
                                regs[i] <= '0;
                end else if (i_we) begin
                        regs[i_wrIdx] <= i_wrData;
                end
        end

        assign o_rdA = regs[i_rdIdxA];
        assign o_rdB = regs[i_rdIdxB];

endmodule

// File: hdl/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
        input  cpuPkg::dataT  i_a,
        input  cpuPkg::dataT  i_b,
        input  cpuPkg::aluOpT i_op,
        output cpuPkg::dataT  o_result,
        output logic          o_n,
        output logic          o_z
);

        cpuPkg::dataT shiftMag;

        // negative amount means right shift by its magnitude
        assign shiftMag = i_b[7] ? -i_b : i_b;

        always_comb begin
                case (i_op)
                cpuPkg::aluAdd:  o_result = i_a + i_b;
                cpuPkg::aluSub:  o_result = i_a - i_b;
                cpuPkg::aluOr:   o_result = i_a | i_b;
                cpuPkg::aluNand: o_result = ~(i_a & i_b);
                cpuPkg::aluShift: begin
                        if (i_b[7])
                                o_result = i_a >> shiftMag;     // logical
                        else
                                o_result = i_a << shiftMag;
                end
                default:         o_result = i_a + i_b;
                endcase
        end

        assign o_n = o_result[7];
        assign o_z = (o_result == '0);

endmodule

// File: hdl/cpuIfs.sv
`timescale 1ns/1ps

interface ctrlIf;
        logic pcWrite;
        logic pcSel;            // 0 alu result, 1 aluOut
        logic memRead;
        logic memWrite;
        logic irLoad;
        logic r1Sel;            // force register one
        logic mdrLoad;
        logic r1r2Load;
        logic alu1Sel;          // 0 pc, 1 r1 latch
        cpuPkg::alu2SelT alu2Sel;
        cpuPkg::aluOpT aluOp;
        logic aluOutWrite;
        logic rfWrite;
        logic regIn;            // 0 aluOut, 1 mdr
        logic flagWrite;
        cpuPkg::instrT instr;
        logic flagN;
        logic flagZ;

        modport seq (
                output pcWrite, pcSel, memRead, memWrite, irLoad, r1Sel, mdrLoad,
                output r1r2Load, alu1Sel, alu2Sel, aluOp, aluOutWrite, rfWrite,
                output regIn, flagWrite,
                input  instr, flagN, flagZ
        );
        modport dp (
                input  pcWrite, pcSel, memRead, memWrite, irLoad, r1Sel, mdrLoad,
                input  r1r2Load, alu1Sel, alu2Sel, aluOp, aluOutWrite, rfWrite,
                input  regIn, flagWrite,
                output instr, flagN, flagZ
        );
endinterface

interface memIf;
        cpuPkg::addrT addr;
        cpuPkg::dataT wdata;
        cpuPkg::dataT rdata;
        logic read;
        logic write;

        modport core (output addr, wdata, read, write, input rdata);
        modport mem (input addr, wdata, read, write, output rdata);
endinterface

// File: hdl/cpuPkg.sv
package cpuPkg;

        typedef logic [7:0] dataT;      // register and memory word
        typedef logic [7:0] addrT;      // memory address and pc
        typedef logic [7:0] instrT;
        typedef logic [1:0] regIdxT;

        localparam int memDepth = 256;

        // register index fields of an instruction
        localparam int r1Hi = 7;
        localparam int r1Lo = 6;
        localparam int r2Hi = 5;
        localparam int r2Lo = 4;

        // full 4-bit opcodes in bits 3:0
        localparam logic [3:0] opLoad  = 4'd0;
        localparam logic [3:0] opStop  = 4'd1;
        localparam logic [3:0] opStore = 4'd2;
        localparam logic [3:0] opAdd   = 4'd4;
        localparam logic [3:0] opBz    = 4'd5;
        localparam logic [3:0] opSub   = 4'd6;
        localparam logic [3:0] opNand  = 4'd8;
        localparam logic [3:0] opBnz   = 4'd9;
        localparam logic [3:0] opNop   = 4'd10;
        localparam logic [3:0] opBpz   = 4'd13;

        // 3-bit opcodes in bits 2:0
        localparam logic [2:0] opShift = 3'd3;
        localparam logic [2:0] opOri   = 3'd7;

        typedef enum logic [2:0] {
                aluAdd   = 3'd0,
                aluSub   = 3'd1,
                aluOr    = 3'd2,
                aluNand  = 3'd3,
                aluShift = 3'd4
        } aluOpT;

        typedef enum logic [2:0] {
                alu2R2   = 3'd0,
                alu2One  = 3'd1,
                alu2Imm4 = 3'd2,        // sign-extended
                alu2Imm5 = 3'd3,        // zero-extended
                alu2Imm3 = 3'd4
        } alu2SelT;

        // asn = add/sub/nand, asnsh = add/sub/nand/shift
        typedef enum logic [4:0] {
                stReset, stFetch, stDecode,
                stC3Asn, stC3Shift, stC3Ori, stC3Load, stC3Store,
                stC3Bz, stC3Bnz, stC3Bpz, stC3Nop, stC3Stop,
                stC4Asnsh, stC4Ori, stC4Load, stC4Idle,
                stC5Ori, stC5Idle,
                stHalted
        } fsmStateT;

endpackage
